// File: bench/commit_cases.txt
// instruction word, expected commit rd, expected commit value
// registers start at zero, values follow program order
06400093 01 00000064 // addi x1, x0, 100
FF900113 02 FFFFFFF9 // addi x2, x0, -7
5A504193 03 000005A5 // xori x3, x0, 0x5a5
0F006213 04 000000F0 // ori  x4, x0, 0xf0
00208333 06 0000005D // add  x6, x1, x2
403303B3 07 FFFFFAB8 // sub  x7, x6, x3
0043F433 08 000000B0 // and  x8, x7, x4
003464B3 09 000005B5 // or   x9, x8, x3
0014C533 0A 000005D1 // xor  x10, x9, x1
007095B3 0B 64000000 // sll  x11, x1, x7
0045D633 0C 00006400 // srl  x12, x11, x4
001126B3 0D 00000001 // slt  x13, x2, x1
00208033 00 00000000 // add  x0, x1, x2
001007B3 0F 00000064 // add  x15, x0, x1
00128293 05 00000001 // addi x5, x5, 1
005282B3 05 00000002 // add  x5, x5, x5
005282B3 05 00000004 // add  x5, x5, x5
00328293 05 00000007 // addi x5, x5, 3
005282B3 05 0000000E // add  x5, x5, x5
0FF2C293 05 000000F1 // xori x5, x5, 0xff
005282B3 05 000001E2 // add  x5, x5, x5
FFE28293 05 000001E0 // addi x5, x5, -2
00D292B3 05 000003C0 // sll  x5, x5, x13
401282B3 05 0000035C // sub  x5, x5, x1
005282B3 05 000006B8 // add  x5, x5, x5
0072E293 05 000006BF // ori  x5, x5, 7
005282B3 05 00000D7E // add  x5, x5, x5
3F02F293 05 00000170 // andi x5, x5, 0x3f0
005282B3 05 000002E0 // add  x5, x5, x5
10028293 05 000003E0 // addi x5, x5, 0x100
00D2D2B3 05 000001F0 // srl  x5, x5, x13
00C2C8B3 11 000065F0 // xor  x17, x5, x12

// File: ooo_core.f
design/core_pkg.sv
design/dispatch_unit.sv
design/rename_table.sv
design/free_list.sv
design/reorder_buffer.sv
design/issue_queue.sv
design/phys_reg_file.sv
design/alu_unit.sv
design/ooo_core.sv
bench/ooo_core_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = ooo_core_tb
FILELIST  = ooo_core.f
SOURCES   = $(shell cat $(FILELIST))
BIN       = obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "Finished with no errors"

clean:
	rm -rf obj_dir

// File: bench/ooo_core_tb.sv
module ooo_core_tb;

    timeunit 1ns;
    timeprecision 1ps;

    // Case file shape and run limits
    localparam int NUM_CASES       = 32;
    localparam int BURST_FROM      = 14;
    localparam int CLK_HALF        = 20;
    localparam int RESET_CYCLES    = 16;
    localparam int WATCHDOG_CYCLES = NUM_CASES * 20;

    logic        clk;
    logic        arst_n;
    logic        inst_valid;
    logic [31:0] inst;
    logic        inst_stall;
    logic        commit_valid;
    logic [4:0]  commit_rd;
    logic [31:0] commit_data;

    // Three words per case with instruction, rd and value
    logic [31:0] case_mem [3*NUM_CASES];
    logic [31:0] rng_state;
    int          commit_count;
    logic        stall_seen;

    ooo_core dut (
        .clk(clk), .arst_n(arst_n), .inst_valid(inst_valid), .inst(inst),
        .inst_stall(inst_stall), .commit_valid(commit_valid), .commit_rd(commit_rd),
        .commit_data(commit_data)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // Label a case by word format and destination
    function automatic string case_name(input int idx);
        core_pkg::inst_word_u w;
        w = case_mem[3*idx];
        if (w.i_view.opcode == core_pkg::OPC_OP_IMM) begin
            return $sformatf("case %0d (I-type x%0d)", idx, w.i_view.rd);
        end
        return $sformatf("case %0d (R-type x%0d)", idx, w.r_view.rd);
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
            $display("Finished with errors");
            $fatal(1, "value check failed");
        end
    endtask

    // Present one word and hold it until the core takes it
    task automatic send_case(input int idx);
        int gap;
        gap = 0;
        // Random idle cycles only ahead of the burst
        if (idx < BURST_FROM) begin
            rng_state = xorshift32(rng_state);
            gap       = int'(rng_state % 32'd3);
        end
        repeat (gap) @(negedge clk);
        inst_valid = 1'b1;
        inst       = case_mem[3*idx];
        // Stall level is stable at the falling edge
        while (inst_stall) begin
            stall_seen = 1'b1;
            @(negedge clk);
        end
        @(negedge clk);
        inst_valid = 1'b0;
    endtask

    // Commit monitor against the expected lines in program order
    always @(negedge clk) begin
        if (arst_n && commit_valid) begin
            if (commit_count < NUM_CASES) begin
                check_value({case_name(commit_count), " rd"},
                            case_mem[3*commit_count+1], {27'b0, commit_rd});
                check_value({case_name(commit_count), " value"},
                            case_mem[3*commit_count+2], commit_data);
            end
            commit_count++;
        end
    end

    // Watchdog sized from the case count
    initial begin
        @(posedge arst_n);
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Error: commits stopped arriving, %0d of %0d cases committed",
                 commit_count, NUM_CASES);
        $display("Finished with errors");
        $fatal(1, "watchdog expired");
    end

    initial begin
        arst_n       = 1'b0;
        inst_valid   = 1'b0;
        inst         = '0;
        rng_state    = 32'd16;
        commit_count = 0;
        stall_seen   = 1'b0;
        $readmemh("bench/commit_cases.txt", case_mem);
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        // Core sits idle out of reset
        repeat (2) begin
            @(negedge clk);
            check_value("idle commit_valid", 32'd0, {31'b0, commit_valid});
            check_value("idle inst_stall", 32'd0, {31'b0, inst_stall});
        end
        for (int i = 0; i < NUM_CASES; i++) begin
            send_case(i);
        end
        wait (commit_count == NUM_CASES);
        // Room for a stray duplicate commit to show
        repeat (10) @(negedge clk);
        // x5 chain issues every other cycle, so the burst must back up
        check_value("stall during burst", 32'd1, {31'b0, stall_seen});
        if (commit_count != NUM_CASES) begin
            $display("Error: %0d commits seen for %0d cases", commit_count, NUM_CASES);
            $display("Finished with errors");
            $fatal(1, "commit count wrong");
        end else begin
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule

// File: design/ooo_core.sv
module ooo_core (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        inst_valid,
    input  logic [31:0] inst,
    output logic        inst_stall,
    output logic        commit_valid,
    output logic [4:0]  commit_rd,
    output logic [31:0] commit_data
);

    // Dispatch outputs
    logic              alloc, use_imm;
    core_pkg::alu_op_e op;
    logic [31:0]       imm;
    logic [4:0]        rs1, rs2, rd;
    // Rename and free list
    logic                        rob_full, iq_full, free_empty, fl_pop;
    logic [core_pkg::PREG_W-1:0] head_preg, dest_preg, old_preg;
    logic [core_pkg::PREG_W-1:0] src1_preg, src2_preg;
    logic                        src1_ready, src2_ready;
    logic [core_pkg::ROB_W-1:0]  alloc_tag;
    logic                        retire;
    logic [core_pkg::PREG_W-1:0] retire_preg;
    // Issue to ALU
    logic                        issue_valid, issue_use_imm;
    core_pkg::alu_op_e           issue_op;
    logic [31:0]                 issue_imm, rdata1, rdata2;
    logic [core_pkg::PREG_W-1:0] issue_src1, issue_src2, issue_dest;
    logic [core_pkg::ROB_W-1:0]  issue_tag;
    // Common data bus
    logic                        cdb_valid;
    logic [core_pkg::PREG_W-1:0] cdb_preg;
    logic [core_pkg::ROB_W-1:0]  cdb_tag;
    logic [31:0]                 cdb_data;

    // x0 destinations take no fresh register and write physical 0
    assign fl_pop    = alloc && (rd != '0);
    assign dest_preg = fl_pop ? head_preg : '0;

    dispatch_unit u_dispatch (
        .inst_valid(inst_valid), .inst(inst), .rob_full(rob_full), .iq_full(iq_full),
        .free_empty(free_empty), .inst_stall(inst_stall), .alloc(alloc), .op(op),
        .imm(imm), .use_imm(use_imm), .rs1(rs1), .rs2(rs2), .rd(rd)
    );

    rename_table u_rat (
        .clk(clk), .arst_n(arst_n), .alloc(alloc), .rs1(rs1), .rs2(rs2), .rd(rd),
        .new_preg(dest_preg), .cdb_valid(cdb_valid), .cdb_preg(cdb_preg),
        .src1_preg(src1_preg), .src1_ready(src1_ready), .src2_preg(src2_preg),
        .src2_ready(src2_ready), .old_preg(old_preg)
    );

    free_list u_free_list (
        .clk(clk), .arst_n(arst_n), .pop(fl_pop), .push(retire), .push_preg(retire_preg),
        .empty(free_empty), .head_preg(head_preg)
    );

    reorder_buffer u_rob (
        .clk(clk), .arst_n(arst_n), .alloc(alloc), .rd(rd), .new_preg(dest_preg),
        .old_preg(old_preg), .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_data(cdb_data),
        .full(rob_full), .alloc_tag(alloc_tag), .commit_valid(commit_valid),
        .commit_rd(commit_rd), .commit_data(commit_data), .retire(retire),
        .retire_preg(retire_preg)
    );

    issue_queue u_iq (
        .clk(clk), .arst_n(arst_n), .alloc(alloc), .op(op), .imm(imm), .use_imm(use_imm),
        .src1_preg(src1_preg), .src1_ready(src1_ready), .src2_preg(src2_preg),
        .src2_ready(src2_ready), .dest_preg(dest_preg), .tag(alloc_tag),
        .cdb_valid(cdb_valid), .cdb_preg(cdb_preg), .full(iq_full),
        .issue_valid(issue_valid), .issue_op(issue_op), .issue_imm(issue_imm),
        .issue_use_imm(issue_use_imm), .issue_src1(issue_src1), .issue_src2(issue_src2),
        .issue_dest(issue_dest), .issue_tag(issue_tag)
    );

    phys_reg_file u_prf (
        .clk(clk), .arst_n(arst_n), .raddr1(issue_src1), .raddr2(issue_src2),
        .rdata1(rdata1), .rdata2(rdata2), .cdb_valid(cdb_valid), .cdb_preg(cdb_preg),
        .cdb_data(cdb_data)
    );

    alu_unit u_alu (
        .clk(clk), .arst_n(arst_n), .issue_valid(issue_valid), .op(issue_op),
        .opa(rdata1), .opb(rdata2), .imm(issue_imm), .use_imm(issue_use_imm),
        .dest(issue_dest), .tag(issue_tag), .cdb_valid(cdb_valid), .cdb_preg(cdb_preg),
        .cdb_tag(cdb_tag), .cdb_data(cdb_data)
    );

endmodule

// File: design/alu_unit.sv
module alu_unit (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        issue_valid,
    input  core_pkg::alu_op_e           op,
    input  logic [31:0]                 opa,
    input  logic [31:0]                 opb,
    input  logic [31:0]                 imm,
    input  logic                        use_imm,
    input  logic [core_pkg::PREG_W-1:0] dest,
    input  logic [core_pkg::ROB_W-1:0]  tag,
    output logic                        cdb_valid,
    output logic [core_pkg::PREG_W-1:0] cdb_preg,
    output logic [core_pkg::ROB_W-1:0]  cdb_tag,
    output logic [31:0]                 cdb_data
);

    logic [31:0] b;
    logic [31:0] result;

    always_comb begin
        b = use_imm ? imm : opb;
        case (op)
            core_pkg::ALU_ADD, core_pkg::ALU_ADDI: result = opa + b;
            core_pkg::ALU_SUB:                     result = opa - b;
            core_pkg::ALU_AND, core_pkg::ALU_ANDI: result = opa & b;
            core_pkg::ALU_OR, core_pkg::ALU_ORI:   result = opa | b;
            core_pkg::ALU_XOR, core_pkg::ALU_XORI: result = opa ^ b;
            // Shift amount is the low five bits
            core_pkg::ALU_SLL: result = opa << b[4:0];
            core_pkg::ALU_SRL: result = opa >> b[4:0];
            core_pkg::ALU_SLT: result = {31'b0, $signed(opa) < $signed(b)};
            default:           result = '0;
        endcase
    end

    // Bus valid one cycle after issue
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cdb_valid <= 1'b0;
        end else begin
            cdb_valid <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            cdb_preg <= dest;
            cdb_tag  <= tag;
            cdb_data <= result;
        end
    end

endmodule

// File: design/phys_reg_file.sv
module phys_reg_file (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic [core_pkg::PREG_W-1:0] raddr1,
    input  logic [core_pkg::PREG_W-1:0] raddr2,
    output logic [31:0]                 rdata1,
    output logic [31:0]                 rdata2,
    input  logic                        cdb_valid,
    input  logic [core_pkg::PREG_W-1:0] cdb_preg,
    input  logic [31:0]                 cdb_data
);

    logic [31:0] regs_q [core_pkg::PHYS_REGS];
    logic        wr_en;

    // Physical 0 backs x0 and is never written
    assign wr_en = cdb_valid && (cdb_preg != '0);

    // Forward the bus write landing this cycle
    assign rdata1 = (wr_en && (cdb_preg == raddr1)) ? cdb_data : regs_q[raddr1];
    assign rdata2 = (wr_en && (cdb_preg == raddr2)) ? cdb_data : regs_q[raddr2];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < core_pkg::PHYS_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en) begin
            regs_q[cdb_preg] <= cdb_data;
        end
    end

endmodule

// File: design/issue_queue.sv
module issue_queue (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        alloc,
    input  core_pkg::alu_op_e           op,
    input  logic [31:0]                 imm,
    input  logic                        use_imm,
    input  logic [core_pkg::PREG_W-1:0] src1_preg,
    input  logic                        src1_ready,
    input  logic [core_pkg::PREG_W-1:0] src2_preg,
    input  logic                        src2_ready,
    input  logic [core_pkg::PREG_W-1:0] dest_preg,
    input  logic [core_pkg::ROB_W-1:0]  tag,
    input  logic                        cdb_valid,
    input  logic [core_pkg::PREG_W-1:0] cdb_preg,
    output logic                        full,
    output logic                        issue_valid,
    output core_pkg::alu_op_e           issue_op,
    output logic [31:0]                 issue_imm,
    output logic                        issue_use_imm,
    output logic [core_pkg::PREG_W-1:0] issue_src1,
    output logic [core_pkg::PREG_W-1:0] issue_src2,
    output logic [core_pkg::PREG_W-1:0] issue_dest,
    output logic [core_pkg::ROB_W-1:0]  issue_tag
);

    // Collapsing table with the oldest entry in slot 0
    core_pkg::alu_op_e           op_q   [core_pkg::IQ_DEPTH];
    logic [31:0]                 imm_q  [core_pkg::IQ_DEPTH];
    logic [core_pkg::PREG_W-1:0] src1_q [core_pkg::IQ_DEPTH];
    logic [core_pkg::PREG_W-1:0] src2_q [core_pkg::IQ_DEPTH];
    logic [core_pkg::PREG_W-1:0] dest_q [core_pkg::IQ_DEPTH];
    logic [core_pkg::ROB_W-1:0]  tag_q  [core_pkg::IQ_DEPTH];
    logic [core_pkg::IQ_DEPTH-1:0] use_imm_q, rdy1_q, rdy2_q;
    logic [core_pkg::IQ_DEPTH-1:0] rdy1_w, rdy2_w, can_issue;
    logic [core_pkg::IQ_W:0]       count_q;
    logic [core_pkg::IQ_W:0]       fill;
    logic [core_pkg::IQ_W-1:0]     sel;

    assign full = (count_q == core_pkg::IQ_DEPTH[core_pkg::IQ_W:0]);
    // New entry lands just past the survivors
    assign fill = count_q - {{core_pkg::IQ_W{1'b0}}, issue_valid};

    always_comb begin
        issue_valid = 1'b0;
        sel         = '0;
        for (int i = 0; i < core_pkg::IQ_DEPTH; i++) begin
            // Wakeup takes effect next cycle
            rdy1_w[i]    = rdy1_q[i] | (cdb_valid && (cdb_preg == src1_q[i]));
            rdy2_w[i]    = rdy2_q[i] | (cdb_valid && (cdb_preg == src2_q[i]));
            can_issue[i] = (i < count_q) && rdy1_q[i] && rdy2_q[i];
        end
        // Lowest ready slot is the oldest
        for (int i = core_pkg::IQ_DEPTH - 1; i >= 0; i--) begin
            if (can_issue[i]) begin
                issue_valid = 1'b1;
                sel         = core_pkg::IQ_W'(i);
            end
        end
    end

    assign issue_op      = op_q[sel];
    assign issue_imm     = imm_q[sel];
    assign issue_use_imm = use_imm_q[sel];
    assign issue_src1    = src1_q[sel];
    assign issue_src2    = src2_q[sel];
    assign issue_dest    = dest_q[sel];
    assign issue_tag     = tag_q[sel];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count_q <= '0;
        end else if (alloc && !issue_valid) begin
            count_q <= count_q + 1'b1;
        end else if (issue_valid && !alloc) begin
            count_q <= count_q - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        rdy1_q <= rdy1_w;
        rdy2_q <= rdy2_w;
        // Close the gap left by the issued slot
        for (int i = 0; i < core_pkg::IQ_DEPTH - 1; i++) begin
            if (issue_valid && (i >= sel)) begin
                op_q[i]      <= op_q[i+1];
                imm_q[i]     <= imm_q[i+1];
                use_imm_q[i] <= use_imm_q[i+1];
                src1_q[i]    <= src1_q[i+1];
                src2_q[i]    <= src2_q[i+1];
                dest_q[i]    <= dest_q[i+1];
                tag_q[i]     <= tag_q[i+1];
                rdy1_q[i]    <= rdy1_w[i+1];
                rdy2_q[i]    <= rdy2_w[i+1];
            end
        end
        if (alloc) begin
            op_q[fill[core_pkg::IQ_W-1:0]]      <= op;
            imm_q[fill[core_pkg::IQ_W-1:0]]     <= imm;
            use_imm_q[fill[core_pkg::IQ_W-1:0]] <= use_imm;
            src1_q[fill[core_pkg::IQ_W-1:0]]    <= src1_preg;
            src2_q[fill[core_pkg::IQ_W-1:0]]    <= src2_preg;
            dest_q[fill[core_pkg::IQ_W-1:0]]    <= dest_preg;
            tag_q[fill[core_pkg::IQ_W-1:0]]     <= tag;
            rdy1_q[fill[core_pkg::IQ_W-1:0]]    <= src1_ready;
            rdy2_q[fill[core_pkg::IQ_W-1:0]]    <= src2_ready;
        end
    end

    // Ready operands of an issued entry are no longer in flight on the bus
    a_issue_ready: assert property (@(posedge clk) disable iff (!arst_n)
        (issue_valid && cdb_valid && (cdb_preg != '0))
        |-> ((cdb_preg != issue_src1) && (cdb_preg != issue_src2)));

endmodule

// File: design/reorder_buffer.sv
module reorder_buffer (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        alloc,
    input  logic [4:0]                  rd,
    input  logic [core_pkg::PREG_W-1:0] new_preg,
    input  logic [core_pkg::PREG_W-1:0] old_preg,
    input  logic                        cdb_valid,
    input  logic [core_pkg::ROB_W-1:0]  cdb_tag,
    input  logic [31:0]                 cdb_data,
    output logic                        full,
    output logic [core_pkg::ROB_W-1:0]  alloc_tag,
    output logic                        commit_valid,
    output logic [4:0]                  commit_rd,
    output logic [31:0]                 commit_data,
    output logic                        retire,
    output logic [core_pkg::PREG_W-1:0] retire_preg
);

    // Per-entry payload
    logic [4:0]                  rd_q   [core_pkg::ROB_DEPTH];
    logic [core_pkg::PREG_W-1:0] old_q  [core_pkg::ROB_DEPTH];
    logic [31:0]                 data_q [core_pkg::ROB_DEPTH];
    // Completion flags and ring pointers
    logic [core_pkg::ROB_DEPTH-1:0] done_q;
    logic [core_pkg::ROB_W-1:0]     head_q;
    logic [core_pkg::ROB_W-1:0]     tail_q;
    logic [core_pkg::ROB_W:0]       count_q;

    assign full      = (count_q == core_pkg::ROB_DEPTH[core_pkg::ROB_W:0]);
    assign alloc_tag = tail_q;

    // Head leaves as soon as its result is in
    assign commit_valid = (count_q != '0) && done_q[head_q];
    assign commit_rd    = rd_q[head_q];
    assign commit_data  = data_q[head_q];
    // Previous mapping goes back to the free list, never for x0
    assign retire       = commit_valid && (rd_q[head_q] != '0);
    assign retire_preg  = old_q[head_q];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            done_q  <= '0;
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (cdb_valid) begin
                done_q[cdb_tag] <= 1'b1;
            end
            if (alloc) begin
                done_q[tail_q] <= 1'b0;
                tail_q         <= tail_q + 1'b1;
            end
            if (commit_valid) begin
                head_q <= head_q + 1'b1;
            end
            if (alloc && !commit_valid) begin
                count_q <= count_q + 1'b1;
            end else if (commit_valid && !alloc) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            rd_q[tail_q]  <= rd;
            old_q[tail_q] <= old_preg;
        end
        // Writes to x0 commit as zero
        if (cdb_valid) begin
            data_q[cdb_tag] <= (rd_q[cdb_tag] == '0) ? '0 : cdb_data;
        end
    end

    a_no_alloc_full: assert property (@(posedge clk) disable iff (!arst_n) alloc |-> !full);
    // Only a real destination gets a fresh register from the free list
    a_dest_matches_rd: assert property (@(posedge clk) disable iff (!arst_n)
        alloc |-> ((rd == '0) == (new_preg == '0)));

endmodule

// File: design/free_list.sv
module free_list (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        pop,
    input  logic                        push,
    input  logic [core_pkg::PREG_W-1:0] push_preg,
    output logic                        empty,
    output logic [core_pkg::PREG_W-1:0] head_preg
);

    logic [core_pkg::PREG_W-1:0] mem_q [core_pkg::FL_DEPTH];
    logic [core_pkg::FL_W-1:0]   head_q;
    logic [core_pkg::FL_W-1:0]   tail_q;
    logic [core_pkg::FL_W:0]     count_q;

    assign empty     = (count_q == '0);
    // Next register to hand out
    assign head_preg = mem_q[head_q];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            // Everything above the architectural range starts free
            for (int i = 0; i < core_pkg::FL_DEPTH; i++) begin
                mem_q[i] <= core_pkg::PREG_W'(core_pkg::ARCH_REGS + i);
            end
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= core_pkg::FL_DEPTH[core_pkg::FL_W:0];
        end else begin
            if (push) begin
                mem_q[tail_q] <= push_preg;
                tail_q        <= tail_q + 1'b1;
            end
            if (pop) begin
                head_q <= head_q + 1'b1;
            end
            // Count moves only on an unmatched push or pop
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // Dispatch must stall before the list runs dry
    a_no_pop_empty: assert property (@(posedge clk) disable iff (!arst_n) pop |-> !empty);
    // Retire never returns more registers than exist
    a_no_push_full: assert property (@(posedge clk) disable iff (!arst_n)
        push |-> (count_q != core_pkg::FL_DEPTH[core_pkg::FL_W:0]));

endmodule

// File: design/rename_table.sv
module rename_table (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        alloc,
    input  logic [4:0]                  rs1,
    input  logic [4:0]                  rs2,
    input  logic [4:0]                  rd,
    input  logic [core_pkg::PREG_W-1:0] new_preg,
    input  logic                        cdb_valid,
    input  logic [core_pkg::PREG_W-1:0] cdb_preg,
    output logic [core_pkg::PREG_W-1:0] src1_preg,
    output logic                        src1_ready,
    output logic [core_pkg::PREG_W-1:0] src2_preg,
    output logic                        src2_ready,
    output logic [core_pkg::PREG_W-1:0] old_preg
);

    // Current speculative mapping
    logic [core_pkg::PREG_W-1:0]    map_q [core_pkg::ARCH_REGS];
    // One ready bit per physical register
    logic [core_pkg::PHYS_REGS-1:0] ready_q;

    // Lookups see the mapping before this cycle's rename
    assign src1_preg = map_q[rs1];
    assign src2_preg = map_q[rs2];
    assign old_preg  = map_q[rd];

    // Result on the bus right now counts as ready
    assign src1_ready = ready_q[src1_preg] | (cdb_valid && (cdb_preg == src1_preg));
    assign src2_ready = ready_q[src2_preg] | (cdb_valid && (cdb_preg == src2_preg));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            // Identity map, everything holds a value
            for (int i = 0; i < core_pkg::ARCH_REGS; i++) begin
                map_q[i] <= core_pkg::PREG_W'(i);
            end
            ready_q <= '1;
        end else begin
            if (cdb_valid) begin
                ready_q[cdb_preg] <= 1'b1;
            end
            // x0 keeps physical 0 forever
            if (alloc && (rd != '0)) begin
                map_q[rd]         <= new_preg;
                ready_q[new_preg] <= 1'b0;
            end
        end
    end

endmodule

// File: design/dispatch_unit.sv
module dispatch_unit (
    input  logic                 inst_valid,
    input  core_pkg::inst_word_u inst,
    input  logic                 rob_full,
    input  logic                 iq_full,
    input  logic                 free_empty,
    output logic                 inst_stall,
    output logic                 alloc,
    output core_pkg::alu_op_e    op,
    output logic [31:0]          imm,
    output logic                 use_imm,
    output logic [4:0]           rs1,
    output logic [4:0]           rs2,
    output logic [4:0]           rd
);

    // Any full structure holds the word at the input
    assign inst_stall = rob_full | iq_full | free_empty;
    assign alloc      = inst_valid & ~inst_stall;

    always_comb begin
        use_imm = (inst.i_view.opcode == core_pkg::OPC_OP_IMM);
        if (use_imm) begin
            // I-type, second source unused
            rs1 = inst.i_view.rs1;
            rs2 = '0;
            rd  = inst.i_view.rd;
            imm = {{20{inst.i_view.imm12[11]}}, inst.i_view.imm12};
            case (inst.i_view.funct3)
                3'b100:  op = core_pkg::ALU_XORI;
                3'b110:  op = core_pkg::ALU_ORI;
                3'b111:  op = core_pkg::ALU_ANDI;
                default: op = core_pkg::ALU_ADDI;
            endcase
        end else begin
            // R-type register-register group
            rs1 = inst.r_view.rs1;
            rs2 = inst.r_view.rs2;
            rd  = inst.r_view.rd;
            imm = '0;
            case (inst.r_view.funct3)
                3'b001:  op = core_pkg::ALU_SLL;
                3'b010:  op = core_pkg::ALU_SLT;
                3'b100:  op = core_pkg::ALU_XOR;
                3'b101:  op = core_pkg::ALU_SRL;
                3'b110:  op = core_pkg::ALU_OR;
                3'b111:  op = core_pkg::ALU_AND;
                // funct7 bit 5 picks SUB over ADD
                default: op = inst.r_view.funct7[5] ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
            endcase
        end
    end

endmodule

// File: design/core_pkg.sv
package core_pkg;

    // Register counts
    localparam int ARCH_REGS = 32;
    localparam int PHYS_REGS = 48;
    localparam int PREG_W    = 6;

    // Reorder buffer and issue queue sizing
    localparam int ROB_DEPTH = 8;
    localparam int ROB_W     = 3;
    localparam int IQ_DEPTH  = 4;
    localparam int IQ_W      = 2;

    // Free list holds whatever is not architecturally mapped
    localparam int FL_DEPTH  = PHYS_REGS - ARCH_REGS;
    localparam int FL_W      = 4;

    // Major opcode of the immediate ALU group
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    // Operations the single ALU understands
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR,
        ALU_XOR, ALU_SLL, ALU_SRL, ALU_SLT,
        ALU_ADDI, ALU_ANDI, ALU_ORI, ALU_XORI
    } alu_op_e;

    // One instruction word, R-type and I-type layouts
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r_view;
        struct packed {
            logic [11:0] imm12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i_view;
    } inst_word_u;

endpackage
